//--- la_core.f
design/la_core_pkg.sv
design/pipe_stage_reg.sv
design/reg_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/writeback_stage.sv
design/la_core_top.sv
verif/la_core_asserts.sv
verif/tb_la_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_la_core
FILELIST  ?= la_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST RESULT: PASS
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# The log decides the result, the pipe hides the exit status
sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/tb_la_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_la_core import la_core_pkg::*; ();

    localparam logic [31:0] PC_BASE        = 32'h1c00_0000;
    localparam logic [31:0] LCG_SEED       = 32'h25a691c9;
    localparam int          TIMEOUT_CYCLES = 200;

    logic      aclk;
    logic      rst;
    logic      inst_valid;
    fetch_t    inst;
    logic      inst_ready;
    logic      trace_valid;
    wb_trace_t trace;
    logic      trace_ready;

    logic        random_bp;   // Random trace_ready when set
    logic [31:0] lcg_state;
    logic [31:0] rnd;

    // Stimulus and expected results per instruction
    logic [31:0] tbl_inst [$];
    logic [4:0]  tbl_rd [$];
    logic [31:0] tbl_val [$];
    logic        tbl_we [$];

    la_core_top dut0 (
        .aclk        (aclk),
        .rst         (rst),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .inst_ready  (inst_ready),
        .trace_valid (trace_valid),
        .trace       (trace),
        .trace_ready (trace_ready)
    );

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Instruction encoders with operands in assembly order
    function automatic logic [31:0] enc_3r(logic [16:0] op, logic [4:0] rd, logic [4:0] rj,
                                           logic [4:0] rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_addi(logic [4:0] rd, logic [4:0] rj, logic [11:0] imm);
        return {OP_ADDIW, imm, rj, rd};
    endfunction

    function automatic logic [31:0] enc_lu12i(logic [4:0] rd, logic [19:0] imm);
        return {OP_LU12IW, imm, rd};
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic add_row(logic [31:0] word, logic [4:0] rd, logic [31:0] val, logic we);
        tbl_inst.push_back(word);
        tbl_rd.push_back(rd);
        tbl_val.push_back(val);
        tbl_we.push_back(we);
    endtask

    task automatic load_table();
        add_row(enc_addi(5'd1, 5'd0, 12'hffb), 5'd1, 32'hffff_fffb, 1'b1);  // r1 = -5
        add_row(enc_lu12i(5'd2, 20'h12345), 5'd2, 32'h1234_5000, 1'b1);
        add_row(enc_3r(OP3R_ADDW, 5'd3, 5'd1, 5'd2), 5'd3, 32'h1234_4ffb, 1'b1);  // Dist 2 and 1
        add_row(enc_3r(OP3R_SUBW, 5'd4, 5'd3, 5'd1), 5'd4, 32'h1234_5000, 1'b1);  // Dist 1 and 3
        add_row(enc_3r(OP3R_SLT, 5'd5, 5'd1, 5'd2), 5'd5, 32'h0000_0001, 1'b1);
        add_row(enc_3r(OP3R_SLTU, 5'd6, 5'd1, 5'd2), 5'd6, 32'h0000_0000, 1'b1);
        add_row(enc_3r(OP3R_AND, 5'd7, 5'd3, 5'd4), 5'd7, 32'h1234_4000, 1'b1);
        add_row(enc_3r(OP3R_OR, 5'd8, 5'd7, 5'd1), 5'd8, 32'hffff_fffb, 1'b1);
        add_row(enc_3r(OP3R_XOR, 5'd9, 5'd8, 5'd2), 5'd9, 32'hedcb_affb, 1'b1);
        add_row(enc_addi(5'd0, 5'd1, 12'h007), 5'd0, 32'h0000_0000, 1'b0);  // Write to r0
        add_row(enc_3r(OP3R_ADDW, 5'd10, 5'd0, 5'd1), 5'd10, 32'hffff_fffb, 1'b1);
        add_row(32'hffff_ffff, 5'd0, 32'h0000_0000, 1'b0);  // Unknown word
        add_row(enc_addi(5'd11, 5'd10, 12'h800), 5'd11, 32'hffff_f7fb, 1'b1);
        add_row(enc_3r(OP3R_SLT, 5'd12, 5'd2, 5'd1), 5'd12, 32'h0000_0000, 1'b1);
        add_row(enc_3r(OP3R_SLTU, 5'd13, 5'd2, 5'd1), 5'd13, 32'h0000_0001, 1'b1);
        add_row(enc_3r(OP3R_SUBW, 5'd14, 5'd0, 5'd11), 5'd14, 32'h0000_0805, 1'b1);
        add_row(enc_lu12i(5'd15, 20'hfffff), 5'd15, 32'hffff_f000, 1'b1);
        add_row(enc_3r(OP3R_ADDW, 5'd16, 5'd15, 5'd14), 5'd16, 32'hffff_f805, 1'b1);
    endtask

    // Starts on a falling edge and returns on the one after the handshake
    task automatic send_inst(input logic [31:0] pc_val, input logic [31:0] word);
        int waited;
        waited = 0;
        inst_valid = 1'b1;
        inst.pc    = pc_val;
        inst.inst  = word;
        #1;
        while (!inst_ready) begin
            @(negedge aclk);
            #1;
            waited++;
            assert (waited < TIMEOUT_CYCLES)
                else report_failure("Core did not accept an instruction within the timeout");
        end
        @(negedge aclk);
    endtask

    task automatic run_pass(input int first);
        for (int i = 0; i < tbl_inst.size(); i++) begin
            send_inst(PC_BASE + 4 * (first + i), tbl_inst[i]);
        end
    endtask

    task automatic check_retires(input int total);
        int          done_cnt;
        int          idle;
        int          row;
        logic [31:0] exp_pc;
        logic [3:0]  exp_we;
        done_cnt = 0;
        idle     = 0;
        while (done_cnt < total) begin
            @(negedge aclk);
            #1;
            if (trace_valid && trace_ready) begin
                row    = done_cnt % tbl_inst.size();
                exp_pc = PC_BASE + 4 * done_cnt;
                exp_we = tbl_we[row] ? 4'hf : 4'h0;
                assert (trace.pc === exp_pc) else report_failure($sformatf(
                    "FAILED trace.pc: got 0x%08h expected 0x%08h", trace.pc, exp_pc));
                assert (trace.rf_we === exp_we) else report_failure($sformatf(
                    "FAILED trace.rf_we: got 0x%0h expected 0x%0h", trace.rf_we, exp_we));
                if (tbl_we[row]) begin
                    assert (trace.rf_wnum === tbl_rd[row]) else report_failure($sformatf(
                        "FAILED trace.rf_wnum: got 0x%02h expected 0x%02h",
                        trace.rf_wnum, tbl_rd[row]));
                    assert (trace.rf_wdata === tbl_val[row]) else report_failure($sformatf(
                        "FAILED trace.rf_wdata: got 0x%08h expected 0x%08h",
                        trace.rf_wdata, tbl_val[row]));
                end
                done_cnt++;
                idle = 0;
            end else begin
                idle++;
                assert (idle < TIMEOUT_CYCLES)
                    else report_failure("No instruction retired within the timeout");
            end
        end
    endtask

    // Nothing may retire twice
    task automatic check_drained();
        repeat (5) begin
            @(negedge aclk);
            #1;
            assert (!trace_valid)
                else report_failure("Trace still valid after the last expected retire");
        end
    endtask

    // Failures of the bound protocol checker
    always @(negedge aclk) begin
        assert (dut0.u_asserts.fail_cnt == 0)
            else report_failure("A protocol assertion in the bound checker failed");
    end

    // Back-pressure on the trace port
    initial begin
        forever begin
            @(negedge aclk);
            if (random_bp) begin
                rnd = lcg_next();
                trace_ready = (rnd[18:17] != 2'b00);
            end else begin
                trace_ready = 1'b1;
            end
        end
    end

    initial begin
        rst         = 1'b1;
        inst_valid  = 1'b0;
        inst        = '0;
        trace_ready = 1'b1;
        random_bp   = 1'b0;
        lcg_state   = LCG_SEED;
        load_table();
        repeat (10) @(posedge aclk);
        @(negedge aclk);
        rst = 1'b0;
        #1;
        assert (inst_ready === 1'b1) else report_failure($sformatf(
            "FAILED inst_ready after reset: got 0x%0h expected 0x1", inst_ready));
        assert (trace_valid === 1'b0) else report_failure($sformatf(
            "FAILED trace_valid after reset: got 0x%0h expected 0x0", trace_valid));
        fork
            begin
                @(negedge aclk);
                run_pass(0);
                random_bp <= 1'b1;   // Second pass under random stalls
                run_pass(tbl_inst.size());
                inst_valid = 1'b0;
            end
            check_retires(2 * tbl_inst.size());
        join
        check_drained();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/la_core_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module la_core_asserts import la_core_pkg::*; (
    input wire       aclk,
    input wire       rst,
    input wire       inst_ready,
    input wire       trace_valid,
    input wb_trace_t trace,
    input wire       trace_ready
);

    int fail_cnt = 0;   // Failed assertion count

    // Stalled trace holds its contents
    a_trace_hold: assert property (@(posedge aclk) disable iff (rst)
        trace_valid && !trace_ready |=> trace_valid && $stable(trace))
        else begin
            $error("trace changed while trace_ready was low");
            fail_cnt++;
        end

    a_reset_state: assert property (@(posedge aclk)
        $fell(rst) |-> inst_ready && !trace_valid)   // First cycle out of reset
        else begin
            $error("pipeline not empty in the first cycle after reset");
            fail_cnt++;
        end

    a_r0_no_write: assert property (@(posedge aclk) disable iff (rst)
        trace_valid && (trace.rf_wnum == '0) |-> (trace.rf_we == 4'h0))
        else begin
            $error("trace reports a write to r0");
            fail_cnt++;
        end

endmodule

bind la_core_top la_core_asserts u_asserts (
    .aclk        (aclk),
    .rst         (rst),
    .inst_ready  (inst_ready),
    .trace_valid (trace_valid),
    .trace       (trace),
    .trace_ready (trace_ready)
);

`default_nettype wire

//--- design/la_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module la_core_top import la_core_pkg::*; (
    input  wire       aclk,
    input  wire       rst,
    // Instruction in
    input  wire       inst_valid,
    input  fetch_t    inst,
    output logic      inst_ready,
    // Retire trace out
    output logic      trace_valid,
    output wb_trace_t trace,
    input  wire       trace_ready
);

    logic      id_valid;
    fetch_t    id_data;
    decode_t   dec_out;
    logic      ex_allowin;
    logic      ex_valid;
    decode_t   ex_data;
    exec_t     exe_out;
    logic      wb_allowin;
    logic      wb_valid;
    exec_t     wb_data;
    fwd_t      ex_fwd;
    fwd_t      wb_fwd;
    rf_write_t rf_write;

    pipe_stage_reg #(.payload_t(fetch_t)) id_reg (
        .aclk (aclk), .rst (rst),
        .in_valid (inst_valid), .in_data (inst), .allowin (inst_ready),
        .out_valid (id_valid), .out_data (id_data), .out_allowin (ex_allowin)
    );

    decode_stage u_decode (
        .aclk (aclk), .id_in (id_data), .ex_fwd (ex_fwd), .wb_fwd (wb_fwd),
        .rf_write (rf_write), .id_out (dec_out)
    );

    pipe_stage_reg #(.payload_t(decode_t)) ex_reg (
        .aclk (aclk), .rst (rst),
        .in_valid (id_valid), .in_data (dec_out), .allowin (ex_allowin),
        .out_valid (ex_valid), .out_data (ex_data), .out_allowin (wb_allowin)
    );

    execute_stage u_execute (
        .ex_in (ex_data), .ex_in_valid (ex_valid), .ex_out (exe_out), .ex_fwd (ex_fwd)
    );

    // Trace consumer back-pressure drives the whole allowin chain
    pipe_stage_reg #(.payload_t(exec_t)) wb_reg (
        .aclk (aclk), .rst (rst),
        .in_valid (ex_valid), .in_data (exe_out), .allowin (wb_allowin),
        .out_valid (wb_valid), .out_data (wb_data), .out_allowin (trace_ready)
    );

    writeback_stage u_writeback (
        .wb_in (wb_data), .wb_in_valid (wb_valid), .trace_ready (trace_ready),
        .trace_valid (trace_valid), .trace (trace), .rf_write (rf_write),
        .wb_fwd (wb_fwd)
    );

endmodule

`default_nettype wire

//--- design/writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_stage import la_core_pkg::*; (
    input  exec_t     wb_in,
    input  wire       wb_in_valid,
    input  wire       trace_ready,
    output logic      trace_valid,
    output wb_trace_t trace,
    output rf_write_t rf_write,
    output fwd_t      wb_fwd
);

    logic retire;

    assign retire      = wb_in_valid && trace_ready;
    assign trace_valid = wb_in_valid;

    assign trace.pc       = wb_in.pc;
    assign trace.rf_we    = wb_in.wen ? RF_WE_ALL : 4'h0;
    assign trace.rf_wnum  = wb_in.rd;
    assign trace.rf_wdata = wb_in.result;

    // Commit to the register file on the retire edge only
    assign rf_write.we   = retire && wb_in.wen;
    assign rf_write.addr = wb_in.rd;
    assign rf_write.data = wb_in.result;

    // Still forwards while the trace is stalled
    assign wb_fwd.valid = wb_in_valid && wb_in.wen;
    assign wb_fwd.rd    = wb_in.rd;
    assign wb_fwd.value = wb_in.result;

endmodule

`default_nettype wire

//--- design/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage import la_core_pkg::*; (
    input  decode_t ex_in,
    input  wire     ex_in_valid,
    output exec_t   ex_out,
    output fwd_t    ex_fwd
);

    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] result;

    assign a = ex_in.src1;
    assign b = ex_in.src2;

    always_comb begin
        case (ex_in.alu_op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'b0, a < b};
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_LUI:  result = b;
            default:  result = '0;
        endcase
    end

    assign ex_out.pc     = ex_in.pc;
    assign ex_out.rd     = ex_in.rd;
    assign ex_out.wen    = ex_in.wen;
    assign ex_out.result = result;

    // Result is final here, so decode never has to wait
    assign ex_fwd.valid = ex_in_valid && ex_in.wen;
    assign ex_fwd.rd    = ex_in.rd;
    assign ex_fwd.value = result;

endmodule

`default_nettype wire

//--- design/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage import la_core_pkg::*; (
    input  wire       aclk,
    input  fetch_t    id_in,
    input  fwd_t      ex_fwd,
    input  fwd_t      wb_fwd,
    input  rf_write_t rf_write,
    output decode_t   id_out
);

    logic [XLEN-1:0]       inst;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rj;
    logic [REG_ADDR_W-1:0] rk;
    logic [XLEN-1:0]       rf_rdata1;
    logic [XLEN-1:0]       rf_rdata2;
    logic [XLEN-1:0]       src1_val;
    logic [XLEN-1:0]       src2_val;
    logic [XLEN-1:0]       imm_si12;
    logic [XLEN-1:0]       imm_ui20;
    logic                  known;

    // Youngest producer wins, r0 is never forwarded
    function automatic logic [XLEN-1:0] fwd_pick(
        input logic [REG_ADDR_W-1:0] rs,
        input logic [XLEN-1:0]       rf_val,
        input fwd_t                  ex_f,
        input fwd_t                  wb_f
    );
        if (rs == '0) return '0;
        if (ex_f.valid && ex_f.rd == rs) return ex_f.value;
        if (wb_f.valid && wb_f.rd == rs) return wb_f.value;
        return rf_val;
    endfunction

    assign inst = id_in.inst;
    assign rd   = inst[4:0];
    assign rj   = inst[9:5];
    assign rk   = inst[14:10];

    assign imm_si12 = {{20{inst[21]}}, inst[21:10]};
    assign imm_ui20 = {inst[24:5], 12'b0};

    reg_file u_rf (
        .aclk   (aclk),
        .rs1    (rj),
        .rs2    (rk),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wr     (rf_write)
    );

    assign src1_val = fwd_pick(rj, rf_rdata1, ex_fwd, wb_fwd);
    assign src2_val = fwd_pick(rk, rf_rdata2, ex_fwd, wb_fwd);

    always_comb begin
        id_out.pc     = id_in.pc;
        id_out.alu_op = ALU_ADD;
        id_out.src1   = src1_val;
        id_out.src2   = src2_val;
        id_out.rd     = rd;
        known         = 1'b1;
        if (inst[31:22] == OP_ADDIW) begin
            id_out.src2 = imm_si12;
        end else if (inst[31:25] == OP_LU12IW) begin
            id_out.alu_op = ALU_LUI;
            id_out.src2   = imm_ui20;
        end else begin
            case (inst[31:15])
                OP3R_ADDW: id_out.alu_op = ALU_ADD;
                OP3R_SUBW: id_out.alu_op = ALU_SUB;
                OP3R_SLT:  id_out.alu_op = ALU_SLT;
                OP3R_SLTU: id_out.alu_op = ALU_SLTU;
                OP3R_AND:  id_out.alu_op = ALU_AND;
                OP3R_OR:   id_out.alu_op = ALU_OR;
                OP3R_XOR:  id_out.alu_op = ALU_XOR;
                default:   known = 1'b0;   // Retires as a no-op
            endcase
        end
        id_out.wen = known && (rd != '0);
    end

endmodule

`default_nettype wire

//--- design/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import la_core_pkg::*; (
    input  wire                   aclk,
    input  wire  [REG_ADDR_W-1:0] rs1,
    input  wire  [REG_ADDR_W-1:0] rs2,
    output logic [XLEN-1:0]       rdata1,
    output logic [XLEN-1:0]       rdata2,
    input  rf_write_t             wr
);

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge aclk) begin
        if (wr.we && wr.addr != '0) begin  // r0 stays zero
            regs[wr.addr] <= wr.data;
        end
    end

    // Asynchronous read ports
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- design/pipe_stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

// One slot of the pipeline with valid/allowin handshake
module pipe_stage_reg #(
    parameter type payload_t = logic
) (
    input  wire      aclk,
    input  wire      rst,
    // Upstream side
    input  wire      in_valid,
    input  payload_t in_data,
    output logic     allowin,
    // Downstream side
    output logic     out_valid,
    output payload_t out_data,
    input  wire      out_allowin
);

    logic     valid_q;
    payload_t data_q;

    // Empty, or the held entry leaves this cycle
    assign allowin = !valid_q || out_allowin;

    always_ff @(posedge aclk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (allowin) begin
            valid_q <= in_valid;
        end
    end

    // Payload register
    always_ff @(posedge aclk) begin
        if (allowin) begin
            data_q <= in_data;
        end
    end

    assign out_valid = valid_q;
    assign out_data  = data_q;

endmodule

`default_nettype wire

//--- design/la_core_pkg.sv
`default_nettype none

package la_core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // 3R major opcodes, inst[31:15]
    localparam logic [16:0] OP3R_ADDW = 17'h00020;
    localparam logic [16:0] OP3R_SUBW = 17'h00022;
    localparam logic [16:0] OP3R_SLT  = 17'h00024;
    localparam logic [16:0] OP3R_SLTU = 17'h00025;
    localparam logic [16:0] OP3R_AND  = 17'h00029;
    localparam logic [16:0] OP3R_OR   = 17'h0002a;
    localparam logic [16:0] OP3R_XOR  = 17'h0002b;

    localparam logic [9:0] OP_ADDIW  = 10'h00a; // inst[31:22]
    localparam logic [6:0] OP_LU12IW = 7'h0a;   // inst[31:25]

    localparam logic [3:0] RF_WE_ALL = 4'hf;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_LUI   // Second operand straight through
    } alu_op_e;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
    } fetch_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        alu_op_e               alu_op;
        logic [XLEN-1:0]       src1;
        logic [XLEN-1:0]       src2;
        logic [REG_ADDR_W-1:0] rd;
        logic                  wen;    // Never set with rd == 0
    } decode_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic                  wen;
        logic [XLEN-1:0]       result;
    } exec_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       value;
    } fwd_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } rf_write_t;

    // Debug trace of one retiring instruction
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [3:0]            rf_we;
        logic [REG_ADDR_W-1:0] rf_wnum;
        logic [XLEN-1:0]       rf_wdata;
    } wb_trace_t;

endpackage

`default_nettype wire
